//--- rtl/dma_defines.svh
// dma engine constants: widths, fifo levels, control bits and max tlp payload
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// pcie payload, check the max payload size of the link
`define DMA_MAX_PAYLOAD_DW    32
`define DMA_MAX_PAYLOAD_BYTES 128

`define DMA_SIZE_W    21  // transfer size in bytes, 1 MB max
`define DMA_ADDR_W    32
`define DMA_SAMPLE_W  64
`define DMA_TX_BUF_MIN 1  // tx_buf_av must be above this

// sample fifo, one full tlp is 16 quadwords
`define DMA_FIFO_DEPTH      64
`define DMA_FIFO_PROG_EMPTY 16  // prog_empty below this
`define DMA_FIFO_PROG_FULL  48  // prog_full at or above this

// control register bits
`define DMA_CTRL_DMAE_BIT   0
`define DMA_CTRL_DMAIE_BIT  1
`define DMA_CTRL_DMARST_BIT 2

`endif

//--- rtl/dma_types_pkg.sv
// dma engine data types for addresses, sizes, payloads, counters and samples
`default_nettype none

`include "dma_defines.svh"

package dma_types_pkg;

    typedef logic [`DMA_ADDR_W-1:0]   host_addr_t;   // host byte address
    typedef logic [`DMA_SIZE_W-1:0]   dma_size_t;    // transfer size in bytes
    typedef logic [7:0]               payload_dw_t;  // tlp payload in DW
    typedef logic [14:0]              tlp_count_t;   // tlps left in a transfer

    // one fifo word, two 32 bit samples
    typedef logic [`DMA_SAMPLE_W-1:0] sample_t;

    typedef logic [2:0]               buf_index_t;   // wraps after 8 buffers
    typedef logic [31:0]              ctrl_reg_t;

endpackage

`default_nettype wire

//--- rtl/dma_state_pkg.sv
// state encodings of the dma request and msi interrupt state machines
`default_nettype none

package dma_state_pkg;

    typedef enum logic [2:0] {
        REQ_IDLE,        // waiting for a dma request
        REQ_FIRST,       // first tlp of a buffer
        REQ_NEXT,        // following tlps
        REQ_WAIT_COMPL,  // tx engine busy with the tlp
        REQ_END          // buffer finished, one cycle
    } req_state_e;

    typedef enum logic {IRQ_IDLE, IRQ_WAIT_RDY} irq_state_e;

endpackage

`default_nettype wire

//--- rtl/tlp_plan_if.sv
// handshake between the request state machine and the tlp splitter
`timescale 1ns/10ps
`default_nettype none

interface tlp_plan_if;

    logic load;     // latch first tlp
    logic advance;  // latch next tlp
    logic clear;    // zero the payload
    logic more;     // tlps still to issue

    modport fsm_mp (
        output load, advance, clear,
        input  more
    );

    modport split_mp (
        input  load, advance, clear,
        output more
    );

endinterface

`default_nettype wire

//--- rtl/tlp_splitter.sv
// tlp splitter: cuts a transfer into max payload tlps plus a remainder tlp
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module tlp_splitter (
    input  wire                       pcie_user_clk,
    input  wire                       pcie_user_rst_n,
    input  dma_types_pkg::dma_size_t  dma_size_i,
    input  dma_types_pkg::host_addr_t dma_ha_i,
    tlp_plan_if.split_mp              plan,
    output dma_types_pkg::payload_dw_t payload_dw_o,
    output dma_types_pkg::host_addr_t  host_addr_o
);

    logic [`DMA_SIZE_W-3:0]      size_dw;     // transfer size in DW
    dma_types_pkg::tlp_count_t   full_tlps;
    dma_types_pkg::payload_dw_t  rem_dw;      // DW left after the full tlps
    dma_types_pkg::tlp_count_t   tlps_to_go;  // full tlps after the current one
    logic                        rem_pending; // remainder tlp not yet issued
    logic                        loaded;

    assign size_dw   = dma_size_i[`DMA_SIZE_W-1:2];  // bytes below one DW dropped
    assign full_tlps = dma_types_pkg::tlp_count_t'(size_dw / `DMA_MAX_PAYLOAD_DW);
    assign rem_dw    = dma_types_pkg::payload_dw_t'(size_dw % `DMA_MAX_PAYLOAD_DW);

    // before load: anything to send at all, after: anything beyond the current tlp
    assign plan.more = loaded ? ((tlps_to_go != '0) || rem_pending) : (size_dw != '0);

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            payload_dw_o <= '0;
            host_addr_o  <= '0;
            tlps_to_go   <= '0;
            rem_pending  <= 1'b0;
            loaded       <= 1'b0;
        end else if (plan.clear) begin
            payload_dw_o <= '0;
            loaded       <= 1'b0;
        end else if (plan.load) begin
            loaded      <= 1'b1;
            host_addr_o <= dma_ha_i;  // base address
            if (full_tlps == '0) begin  // short transfer, single remainder tlp
                payload_dw_o <= rem_dw;
                tlps_to_go   <= '0;
                rem_pending  <= 1'b0;
            end else begin
                payload_dw_o <= dma_types_pkg::payload_dw_t'(`DMA_MAX_PAYLOAD_DW);
                tlps_to_go   <= full_tlps - 1'b1;
                rem_pending  <= (rem_dw != '0);
            end
        end else if (plan.advance) begin
            host_addr_o <= host_addr_o + `DMA_MAX_PAYLOAD_BYTES;
            if (tlps_to_go != '0) begin
                payload_dw_o <= dma_types_pkg::payload_dw_t'(`DMA_MAX_PAYLOAD_DW);
                tlps_to_go   <= tlps_to_go - 1'b1;
            end else begin
                payload_dw_o <= rem_dw;  // last one, the remainder
                rem_pending  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dma_req_fsm.sv
// dma request state machine: issues write tlp requests and counts finished buffers
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module dma_req_fsm (
    input  wire                        pcie_user_clk,
    input  wire                        pcie_user_rst_n,
    input  wire                        dma_en_i,
    input  wire                        host_addr_valid_i,
    input  wire  [5:0]                 tx_buf_av_i,
    input  wire                        fifo_prog_empty_i,
    input  wire                        dma_tlp_compl_done_i,
    tlp_plan_if.fsm_mp                 plan,
    output logic                       tlp_req_o,
    output logic                       req_end_o,
    output dma_types_pkg::buf_index_t  buf_index_o
);

    dma_state_pkg::req_state_e state;
    logic [2:0] dmae_r;    // enable delay line
    logic       req_flag;  // enable rise seen, request pending
    logic       tx_ready;
    logic       abort;

    // tx buffers free and a full tlp worth of samples in the fifo
    assign tx_ready = (tx_buf_av_i > 6'(`DMA_TX_BUF_MIN)) && !fifo_prog_empty_i;

    assign plan.load    = (state == dma_state_pkg::REQ_FIRST) && plan.more && tx_ready;
    assign plan.advance = (state == dma_state_pkg::REQ_NEXT) && plan.more && tx_ready;

    // enable dropped while stuck waiting
    assign abort = !dma_en_i && (
        ((state inside {dma_state_pkg::REQ_FIRST, dma_state_pkg::REQ_NEXT})
            && plan.more && !tx_ready) ||
        ((state == dma_state_pkg::REQ_WAIT_COMPL) && !dma_tlp_compl_done_i));

    assign plan.clear = ((state == dma_state_pkg::REQ_NEXT) && !plan.more) || abort;
    assign req_end_o  = (state == dma_state_pkg::REQ_END);

    //////////////////////////////
    // request sequencing
    //////////////////////////////
    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            state       <= dma_state_pkg::REQ_IDLE;
            dmae_r      <= '0;
            req_flag    <= 1'b0;
            tlp_req_o   <= 1'b0;
            buf_index_o <= '0;  // start at buffer 0
        end else begin
            dmae_r <= {dmae_r[1:0], dma_en_i};
            if (dmae_r[2:1] == 2'b01)  // rising edge of DMAE
                req_flag <= 1'b1;

            case (state)
                dma_state_pkg::REQ_IDLE: begin
                    if (req_flag && host_addr_valid_i)  // host must set the address first
                        state <= dma_state_pkg::REQ_FIRST;
                end
                dma_state_pkg::REQ_FIRST: begin
                    req_flag <= 1'b0;
                    if (!plan.more) begin  // under one DW, nothing to send
                        state <= dma_state_pkg::REQ_IDLE;
                    end else if (plan.load) begin
                        tlp_req_o <= 1'b1;
                        state     <= dma_state_pkg::REQ_WAIT_COMPL;
                    end else if (abort) begin
                        state <= dma_state_pkg::REQ_IDLE;
                    end
                end
                dma_state_pkg::REQ_NEXT: begin
                    if (!plan.more) begin  // buffer done
                        buf_index_o <= buf_index_o + 1'b1;
                        state       <= dma_state_pkg::REQ_END;
                    end else if (plan.advance) begin
                        tlp_req_o <= 1'b1;
                        state     <= dma_state_pkg::REQ_WAIT_COMPL;
                    end else if (abort) begin
                        state <= dma_state_pkg::REQ_IDLE;
                    end
                end
                dma_state_pkg::REQ_WAIT_COMPL: begin  // tx engine draining the fifo
                    if (dma_tlp_compl_done_i) begin
                        tlp_req_o <= 1'b0;
                        state     <= dma_state_pkg::REQ_NEXT;
                    end else if (abort) begin
                        tlp_req_o <= 1'b0;
                        state     <= dma_state_pkg::REQ_IDLE;
                    end
                end
                dma_state_pkg::REQ_END: state <= dma_state_pkg::REQ_IDLE;
                default:                state <= dma_state_pkg::REQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/msi_irq_fsm.sv
// msi interrupt state machine: delayed buffer-end interrupt and completion status
`timescale 1ns/10ps
`default_nettype none

module msi_irq_fsm (
    input  wire  pcie_user_clk,
    input  wire  pcie_user_rst_n,
    input  wire  irq_en_i,
    input  wire  req_end_i,
    input  wire  cfg_interrupt_rdy_i,
    output logic cfg_interrupt_o,
    output logic dma_done_o
);

    dma_state_pkg::irq_state_e state;
    logic [1:0] start_r;  // req_end delay line

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n) begin
            state           <= dma_state_pkg::IRQ_IDLE;
            start_r         <= '0;
            cfg_interrupt_o <= 1'b0;
            dma_done_o      <= 1'b0;
        end else begin
            start_r <= {start_r[0], req_end_i};
            case (state)
                dma_state_pkg::IRQ_IDLE: begin
                    if (irq_en_i && start_r[1]) begin
                        cfg_interrupt_o <= 1'b1;
                        dma_done_o      <= 1'b1;  // sticky until reset
                        state           <= dma_state_pkg::IRQ_WAIT_RDY;
                    end
                end
                dma_state_pkg::IRQ_WAIT_RDY: begin
                    if (cfg_interrupt_rdy_i) begin  // core took the msi
                        cfg_interrupt_o <= 1'b0;
                        state           <= dma_state_pkg::IRQ_IDLE;
                    end
                end
                default: state <= dma_state_pkg::IRQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/sample_fifo.sv
// sample fifo: first-word-fall-through buffer with level flags and pcie byte order
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module sample_fifo (
    input  wire                     pcie_user_clk,
    input  wire                     pcie_user_rst_n,
    input  wire                     flush_i,
    input  wire                     wr_en_i,
    input  dma_types_pkg::sample_t  data_i,
    input  wire                     rd_en_i,
    output dma_types_pkg::sample_t  data_o,
    output logic                    prog_empty_o,
    output logic                    prog_full_o
);

    localparam int AW = $clog2(`DMA_FIFO_DEPTH);

    dma_types_pkg::sample_t mem [0:`DMA_FIFO_DEPTH-1];
    dma_types_pkg::sample_t head;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;       // occupancy
    logic [AW:0]   count_nxt;
    logic          do_wr;
    logic          do_rd;

    assign do_wr     = wr_en_i && (count != (AW+1)'(`DMA_FIFO_DEPTH)) && !flush_i;
    assign do_rd     = rd_en_i && (count != '0) && !flush_i;
    assign count_nxt = flush_i ? '0 : count + do_wr - do_rd;

    always_ff @(posedge pcie_user_clk) begin
        if (do_wr)
            mem[wr_ptr] <= data_i;  // payload only
    end

    always_ff @(posedge pcie_user_clk) begin
        if (!pcie_user_rst_n || flush_i) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            prog_empty_o <= 1'b1;
            prog_full_o  <= 1'b0;
        end else begin
            wr_ptr       <= wr_ptr + do_wr;  // pointers wrap at depth
            rd_ptr       <= rd_ptr + do_rd;
            count        <= count_nxt;
            prog_empty_o <= count_nxt < `DMA_FIFO_PROG_EMPTY;
            prog_full_o  <= count_nxt >= `DMA_FIFO_PROG_FULL;
        end
    end

    // head word, byte reversed in each 32 bit half for pcie
    assign head = mem[rd_ptr];
    for (genvar i = 0; i < `DMA_SAMPLE_W / 8; i++) begin : g_swap
        assign data_o[i*8 +: 8] = head[(i ^ 3)*8 +: 8];
    end

endmodule

`default_nettype wire

//--- rtl/pci_dma_engine.sv
// pcie dma engine top: request, tlp splitting, msi interrupt and sample buffering
`timescale 1ns/10ps
`default_nettype none

`include "dma_defines.svh"

module pci_dma_engine (
    input  wire                         pcie_user_clk,
    input  wire                         pcie_user_rst_n,
    // registers
    input  dma_types_pkg::ctrl_reg_t    control_reg_i,
    input  dma_types_pkg::dma_size_t    dma_size_i,      // bytes
    input  dma_types_pkg::host_addr_t   dma_ha_ch0_i,
    // pcie core
    input  wire  [5:0]                  tx_buf_av_i,     // transmit buffers available
    input  wire                         cfg_interrupt_rdy_i,
    output logic                        cfg_interrupt_o,
    // tx engine
    input  wire                         fifo_rd_en_i,
    input  wire                         dma_tlp_compl_done_i,
    output logic                        tlp_req_o,
    output dma_types_pkg::payload_dw_t  dma_tlp_payload_size_o,  // DW
    output dma_types_pkg::host_addr_t   host_addr_tx_o,
    output dma_types_pkg::sample_t      dma_data_tx_o,
    // samples
    input  dma_types_pkg::sample_t      adc_data_i,
    input  wire                         adc_data_en_i,
    output logic                        data_ready_ch0_o,
    // status
    output logic [7:0]                  dma_status_o
);

    logic dmae;
    logic dmaie;
    logic dma_rst;
    logic ha_valid;
    logic prog_empty;
    logic prog_full;
    logic req_end;
    logic dma_done;
    dma_types_pkg::buf_index_t buf_index;

    tlp_plan_if u_plan ();

    //////////////////////////////
    // control and status
    //////////////////////////////
    assign dmae     = control_reg_i[`DMA_CTRL_DMAE_BIT];
    assign dmaie    = control_reg_i[`DMA_CTRL_DMAIE_BIT];
    assign dma_rst  = control_reg_i[`DMA_CTRL_DMARST_BIT];  // flushes the fifo
    assign ha_valid = (dma_ha_ch0_i != '0);  // no dma to address 0

    assign data_ready_ch0_o = !prog_full;  // source throttle
    assign dma_status_o     = {3'b000, prog_empty, dma_done, buf_index};

    tlp_splitter u_splitter (
        .pcie_user_clk   (pcie_user_clk),
        .pcie_user_rst_n (pcie_user_rst_n),
        .dma_size_i      (dma_size_i),
        .dma_ha_i        (dma_ha_ch0_i),
        .plan            (u_plan.split_mp),
        .payload_dw_o    (dma_tlp_payload_size_o),
        .host_addr_o     (host_addr_tx_o)
    );

    dma_req_fsm u_req_fsm (
        .pcie_user_clk        (pcie_user_clk),
        .pcie_user_rst_n      (pcie_user_rst_n),
        .dma_en_i             (dmae),
        .host_addr_valid_i    (ha_valid),
        .tx_buf_av_i          (tx_buf_av_i),
        .fifo_prog_empty_i    (prog_empty),
        .dma_tlp_compl_done_i (dma_tlp_compl_done_i),
        .plan                 (u_plan.fsm_mp),
        .tlp_req_o            (tlp_req_o),
        .req_end_o            (req_end),
        .buf_index_o          (buf_index)
    );

    msi_irq_fsm u_irq_fsm (
        .pcie_user_clk       (pcie_user_clk),
        .pcie_user_rst_n     (pcie_user_rst_n),
        .irq_en_i            (dmaie),
        .req_end_i           (req_end),
        .cfg_interrupt_rdy_i (cfg_interrupt_rdy_i),
        .cfg_interrupt_o     (cfg_interrupt_o),
        .dma_done_o          (dma_done)
    );

    sample_fifo u_fifo (
        .pcie_user_clk   (pcie_user_clk),
        .pcie_user_rst_n (pcie_user_rst_n),
        .flush_i         (dma_rst),
        .wr_en_i         (adc_data_en_i),
        .data_i          (adc_data_i),
        .rd_en_i         (fifo_rd_en_i),
        .data_o          (dma_data_tx_o),  // already byte swapped
        .prog_empty_o    (prog_empty),
        .prog_full_o     (prog_full)
    );

endmodule

`default_nettype wire

//--- tb/pci_dma_engine_assert.sv
// protocol checks on tlp requests and the msi handshake, bound into the design
`timescale 1ns/10ps
`default_nettype none

module pci_dma_engine_assert (
    input wire                        pcie_user_clk,
    input wire                        pcie_user_rst_n,
    input wire                        tlp_req_i,
    input dma_types_pkg::payload_dw_t payload_i,  // payload size seen by the tx engine
    input wire                        cfg_interrupt_i,
    input wire                        cfg_interrupt_rdy_i
);

    // a request never goes out with an empty payload
    a_req_has_payload: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        $rose(tlp_req_i) |-> (payload_i != '0))
        else $error("tlp request raised with a zero payload");

    // msi request held until the core takes it
    a_irq_held: assert property (@(posedge pcie_user_clk) disable iff (!pcie_user_rst_n)
        (cfg_interrupt_i && !cfg_interrupt_rdy_i) |=> cfg_interrupt_i)
        else $error("cfg_interrupt dropped before rdy");

endmodule

//////////////////////////////
// bindings
//////////////////////////////
bind pci_dma_engine pci_dma_engine_assert u_req_assert (
    .pcie_user_clk       (pcie_user_clk),
    .pcie_user_rst_n     (pcie_user_rst_n),
    .tlp_req_i           (tlp_req_o),
    .payload_i           (dma_tlp_payload_size_o),
    .cfg_interrupt_i     (1'b0),  // irq side checked in msi_irq_fsm
    .cfg_interrupt_rdy_i (1'b0)
);

bind msi_irq_fsm pci_dma_engine_assert u_irq_assert (
    .pcie_user_clk       (pcie_user_clk),
    .pcie_user_rst_n     (pcie_user_rst_n),
    .tlp_req_i           (1'b0),
    .payload_i           (8'd0),
    .cfg_interrupt_i     (cfg_interrupt_o),
    .cfg_interrupt_rdy_i (cfg_interrupt_rdy_i)
);

`default_nettype wire

//--- tb/tb_pci_dma_engine.sv
// directed testbench for the pcie dma engine with a tx engine model and a watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_pci_dma_engine;

    localparam int CLK_PERIOD  = 40;    // ns
    localparam int WAIT_LIMIT  = 200;   // cycles for one handshake
    localparam int TEST_CYCLES = 250;   // longest test, 48 writes or fill plus two tlps
    localparam int NUM_TESTS   = 9;
    localparam int RUN_CYCLES  = NUM_TESTS * TEST_CYCLES + 500;  // plus margin
    localparam dma_types_pkg::host_addr_t BASE_ADDR = 32'h8000_1000;
    localparam dma_types_pkg::ctrl_reg_t  DMAE      = 32'h1;
    localparam dma_types_pkg::ctrl_reg_t  DMAIE     = 32'h2;
    localparam dma_types_pkg::ctrl_reg_t  DMARST    = 32'h4;

    logic                        pcie_user_clk;
    logic                        pcie_user_rst_n;
    dma_types_pkg::ctrl_reg_t    control_reg;
    dma_types_pkg::dma_size_t    dma_size;
    dma_types_pkg::host_addr_t   dma_ha;
    logic [5:0]                  tx_buf_av;
    logic                        cfg_interrupt_rdy;
    logic                        cfg_interrupt;
    logic                        fifo_rd_en;
    logic                        compl_done;
    logic                        tlp_req;
    dma_types_pkg::payload_dw_t  payload_dw;
    dma_types_pkg::host_addr_t   host_addr_tx;
    dma_types_pkg::sample_t      data_tx;
    dma_types_pkg::sample_t      adc_data;
    logic                        adc_data_en;
    logic                        data_ready;
    logic [7:0]                  dma_status;

    dma_types_pkg::sample_t      ref_q[$];   // words in the fifo, oldest first
    logic [31:0]                 rng_state;
    int                          err_count;
    dma_types_pkg::buf_index_t   buf_count;  // expected finished buffers
    logic                        done_exp;   // expected sticky done bit

    pci_dma_engine u_dut (
        .pcie_user_clk          (pcie_user_clk),
        .pcie_user_rst_n        (pcie_user_rst_n),
        .control_reg_i          (control_reg),
        .dma_size_i             (dma_size),
        .dma_ha_ch0_i           (dma_ha),
        .tx_buf_av_i            (tx_buf_av),
        .cfg_interrupt_rdy_i    (cfg_interrupt_rdy),
        .cfg_interrupt_o        (cfg_interrupt),
        .fifo_rd_en_i           (fifo_rd_en),
        .dma_tlp_compl_done_i   (compl_done),
        .tlp_req_o              (tlp_req),
        .dma_tlp_payload_size_o (payload_dw),
        .host_addr_tx_o         (host_addr_tx),
        .dma_data_tx_o          (data_tx),
        .adc_data_i             (adc_data),
        .adc_data_en_i          (adc_data_en),
        .data_ready_ch0_o       (data_ready),
        .dma_status_o           (dma_status)
    );

    initial begin
        pcie_user_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pcie_user_clk = ~pcie_user_clk;
    end

    //////////////////////////////
    // reference model helpers
    //////////////////////////////
    function automatic logic [31:0] next_rand();  // xorshift32
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // pcie byte order, each 32 bit half reversed
    function automatic dma_types_pkg::sample_t pcie_order(dma_types_pkg::sample_t w);
        return {w[39:32], w[47:40], w[55:48], w[63:56],
                w[7:0],   w[15:8],  w[23:16], w[31:24]};
    endfunction

    function automatic logic [7:0] status_byte(logic prog_empty);
        return {3'b000, prog_empty, done_exp, buf_count};
    endfunction

    //////////////////////////////
    // failure and compare tasks
    //////////////////////////////
    task automatic fail_now();
        err_count++;
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic stop_run(string why);
        $display("%s", why);
        fail_now();
    endtask

    task automatic report_mismatch(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        fail_now();
    endtask

    task automatic check_addr(dma_types_pkg::host_addr_t got, dma_types_pkg::host_addr_t exp,
                              string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_payload(dma_types_pkg::payload_dw_t got,
                                 dma_types_pkg::payload_dw_t exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %0d DW, expected %0d DW", what, got, exp));
    endtask

    task automatic check_sample(dma_types_pkg::sample_t got, dma_types_pkg::sample_t exp,
                                string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_status(logic [7:0] got, logic [7:0] exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    //////////////////////////////
    // stimulus and tx engine model
    //////////////////////////////
    task automatic push_samples(int n);
        repeat (n) begin
            @(negedge pcie_user_clk);
            adc_data    = {next_rand(), next_rand()};
            adc_data_en = 1'b1;
            ref_q.push_back(adc_data);
        end
        @(negedge pcie_user_clk);
        adc_data_en = 1'b0;
    endtask

    task automatic start_dma(dma_types_pkg::dma_size_t size, dma_types_pkg::host_addr_t addr,
                             dma_types_pkg::ctrl_reg_t ctrl);
        @(negedge pcie_user_clk);
        dma_size    = size;
        dma_ha      = addr;
        control_reg = ctrl;  // enable rise starts the request
    endtask

    task automatic stop_dma();
        @(negedge pcie_user_clk);
        control_reg = '0;
        repeat (4) @(negedge pcie_user_clk);  // enable delay line sees the low
    endtask

    task automatic flush_fifo();
        @(negedge pcie_user_clk);
        control_reg = DMARST;
        @(negedge pcie_user_clk);
        control_reg = '0;
        ref_q.delete();
    endtask

    task automatic wait_req();
        int n;
        n = 0;
        while (tlp_req !== 1'b1) begin
            if (n == WAIT_LIMIT)
                stop_run("no TLP request came from the DUT within the wait limit");
            @(negedge pcie_user_clk);
            n++;
        end
    endtask

    // one tlp: read dw/2 quadwords, then pulse completion
    task automatic serve_tlp(dma_types_pkg::payload_dw_t dw, dma_types_pkg::host_addr_t addr);
        wait_req();
        check_payload(payload_dw, dw, "tlp payload");
        check_addr(host_addr_tx, addr, "tlp host address");
        repeat (dw / 2) begin
            check_sample(data_tx, pcie_order(ref_q.pop_front()), "fifo head word");
            fifo_rd_en = 1'b1;
            @(negedge pcie_user_clk);
        end
        fifo_rd_en = 1'b0;
        compl_done = 1'b1;
        @(negedge pcie_user_clk);
        compl_done = 1'b0;
        check_flag(tlp_req, 1'b0, "tlp_req_o after completion");
    endtask

    task automatic end_buffer(logic prog_empty);
        buf_count++;
        repeat (3) @(negedge pcie_user_clk);
        check_payload(payload_dw, '0, "payload after buffer end");
        check_status(dma_status, status_byte(prog_empty), "status after buffer end");
    endtask

    task automatic expect_quiet(int cycles);
        repeat (cycles) begin
            @(negedge pcie_user_clk);
            check_flag(tlp_req, 1'b0, "tlp_req_o while held off");
            check_flag(cfg_interrupt, 1'b0, "cfg_interrupt_o while held off");
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_reset();
        @(negedge pcie_user_clk);
        check_flag(tlp_req, 1'b0, "tlp_req_o after reset");
        check_flag(cfg_interrupt, 1'b0, "cfg_interrupt_o after reset");
        check_payload(payload_dw, '0, "payload after reset");
        check_addr(host_addr_tx, '0, "host address after reset");
        check_flag(data_ready, 1'b1, "data_ready_ch0_o after reset");
        check_status(dma_status, status_byte(1'b1), "status after reset");
    endtask

    task automatic test_full_tlps();
        push_samples(32);
        start_dma(21'd256, BASE_ADDR, DMAE);
        serve_tlp(8'd32, BASE_ADDR);
        serve_tlp(8'd32, BASE_ADDR + 32'd128);
        end_buffer(1'b1);
        stop_dma();
    endtask

    task automatic test_remainder();
        push_samples(32);
        start_dma(21'd200, BASE_ADDR, DMAE);
        serve_tlp(8'd32, BASE_ADDR);
        serve_tlp(8'd18, BASE_ADDR + 32'd128);  // 50 DW, 18 left
        end_buffer(1'b1);                       // 7 words left, below prog-empty
        stop_dma();
        flush_fifo();
    endtask

    task automatic test_interrupt();
        int n;
        push_samples(16);
        start_dma(21'd128, BASE_ADDR, DMAE | DMAIE);
        serve_tlp(8'd32, BASE_ADDR);
        end_buffer(1'b1);
        n = 0;
        while (cfg_interrupt !== 1'b1) begin
            if (n == WAIT_LIMIT)
                stop_run("no MSI request appeared after the end of the buffer");
            @(negedge pcie_user_clk);
            n++;
        end
        done_exp = 1'b1;
        repeat (5) begin  // no rdy yet, request must hold
            @(negedge pcie_user_clk);
            check_flag(cfg_interrupt, 1'b1, "cfg_interrupt_o before rdy");
        end
        cfg_interrupt_rdy = 1'b1;
        @(negedge pcie_user_clk);
        cfg_interrupt_rdy = 1'b0;
        check_flag(cfg_interrupt, 1'b0, "cfg_interrupt_o after rdy");
        check_status(dma_status, status_byte(1'b1), "status after the msi");
        stop_dma();
        check_status(dma_status, status_byte(1'b1), "sticky done bit");
    endtask

    task automatic test_low_tx_buf();
        push_samples(16);
        tx_buf_av = 6'd1;  // not above the minimum
        start_dma(21'd128, BASE_ADDR, DMAE);
        expect_quiet(20);
        tx_buf_av = 6'd8;
        serve_tlp(8'd32, BASE_ADDR);
        end_buffer(1'b1);
        stop_dma();
    endtask

    task automatic test_low_fifo();
        push_samples(8);
        start_dma(21'd128, BASE_ADDR, DMAE);
        expect_quiet(20);
        push_samples(8);  // reaches one full tlp
        serve_tlp(8'd32, BASE_ADDR);
        end_buffer(1'b1);
        stop_dma();
    endtask

    task automatic test_abort();
        push_samples(16);
        tx_buf_av = 6'd1;
        start_dma(21'd128, BASE_ADDR, DMAE | DMAIE);
        repeat (8) @(negedge pcie_user_clk);  // stuck in first
        control_reg = DMAIE;                  // enable dropped
        @(negedge pcie_user_clk);
        tx_buf_av = 6'd8;
        expect_quiet(20);
        check_status(dma_status, status_byte(1'b0), "status after abort");
        stop_dma();
        flush_fifo();
    endtask

    task automatic test_zero_addr();
        push_samples(16);
        start_dma(21'd128, '0, DMAE);
        expect_quiet(20);
        stop_dma();
        flush_fifo();
    endtask

    task automatic test_fifo_levels();
        push_samples(47);
        check_flag(data_ready, 1'b1, "data_ready_ch0_o at 47 words");
        push_samples(1);
        check_flag(data_ready, 1'b0, "data_ready_ch0_o at 48 words");
        check_status(dma_status, status_byte(1'b0), "status with a full fifo");
        fifo_rd_en = 1'b1;
        void'(ref_q.pop_front());
        @(negedge pcie_user_clk);
        fifo_rd_en = 1'b0;
        check_flag(data_ready, 1'b1, "data_ready_ch0_o back below 48 words");
        flush_fifo();
        check_status(dma_status, status_byte(1'b1), "status after dma reset");
    endtask

    // run time limit from the test budget
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        stop_run("watchdog expired, the tests did not finish in time");
    end

    initial begin
        pcie_user_rst_n   = 1'b0;
        control_reg       = '0;
        dma_size          = '0;
        dma_ha            = '0;
        tx_buf_av         = 6'd8;
        cfg_interrupt_rdy = 1'b0;
        fifo_rd_en        = 1'b0;
        compl_done        = 1'b0;
        adc_data          = '0;
        adc_data_en       = 1'b0;
        rng_state         = 32'd46221;
        err_count         = 0;
        buf_count         = '0;
        done_exp          = 1'b0;
        repeat (3) @(posedge pcie_user_clk);
        @(negedge pcie_user_clk);
        pcie_user_rst_n = 1'b1;

        test_reset();
        test_full_tlps();
        test_remainder();
        test_interrupt();
        test_low_tx_buf();
        test_low_fifo();
        test_abort();
        test_zero_addr();  // leaves a pending request, address stays zero
        test_fifo_levels();

        if (err_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/dma_types_pkg.sv
rtl/dma_state_pkg.sv
rtl/tlp_plan_if.sv
rtl/tlp_splitter.sv
rtl/dma_req_fsm.sv
rtl/msi_irq_fsm.sv
rtl/sample_fifo.sv
rtl/pci_dma_engine.sv
tb/pci_dma_engine_assert.sv
tb/tb_pci_dma_engine.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pci_dma_engine -f tb.f

./obj_dir/Vtb_pci_dma_engine 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "Done: no errors" sim.log
echo "simulation passed"
